// ==== testbench/dc_channel_stim.txt ====
# last flag, input word (also the expected output word), expected length, expected checksum
# length and checksum are checked only on rows whose last flag is 1
0 11110000 0000 0000
0 00002222 0000 0000
1 33334444 0003 4444
1 ABCD1234 0001 B9F9
1 0000FFFF 0001 FFFF
0 C0DE0001 0000 0000
0 C0DE0002 0000 0000
0 C0DE0003 0000 0000
0 C0DE0004 0000 0000
0 C0DE0005 0000 0000
0 C0DE0006 0000 0000
0 C0DE0007 0000 0000
0 C0DE0008 0000 0000
0 C0DE0009 0000 0000
1 C0DE000A 000A 000B
0 FFFF0000 0000 0000
1 12345678 0002 BBB3
1 80000001 0001 8001

// ==== compile.f ====
+incdir+source
source/dc_entry_pkg.sv
source/dc_frame_pkg.sv
source/dc_data_buffer.sv
source/dc_fifo.sv
source/dc_frame_writer.sv
source/dc_frame_reader.sv
source/dc_channel_top.sv
testbench/dc_channel_properties.sv
testbench/dc_channel_tb.sv

// ==== Makefile ====
# Verilator build, run and lint for the framed word channel

TOP = dc_channel_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert -Wno-fatal -f compile.f --top-module $(TOP) -o $(TOP)

# Verdict comes from the log, not from the simulator status
run: build
	./obj_dir/$(TOP) +verilator+error+limit+100 > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "Regression failed" sim.log; then exit 1; fi
	@grep -q "Regression passed" sim.log

lint:
	verilator --lint-only --timing --assert -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

// ==== testbench/dc_channel_tb.sv ====
`include "dc_defs.svh"

module dc_channel_tb;

    localparam int CLK_PERIOD      = 8;
    localparam int RESET_CYCLES    = 5;
    localparam int MAX_WORDS       = 64;
    localparam int CYCLES_PER_WORD = 200;
    // Opening back-pressure, long enough to fill the FIFO
    localparam int FIRST_STALL     = 60;

    logic                        clk;
    logic                        rstn;
    logic                        in_valid;
    logic [`DC_DATA_WIDTH-1:0]   in_data;
    logic                        in_last;
    logic                        in_ready;
    logic                        out_valid;
    logic [`DC_DATA_WIDTH-1:0]   out_data;
    logic                        out_last;
    logic [`DC_COUNT_WIDTH-1:0]  out_len;
    logic [`DC_COUNT_WIDTH-1:0]  out_sum;
    logic                        out_ready;

    // Expected stream, one row per input word
    logic [`DC_DATA_WIDTH-1:0]   word_table [MAX_WORDS];
    logic                        last_table [MAX_WORDS];
    logic [`DC_COUNT_WIDTH-1:0]  len_table  [MAX_WORDS];
    logic [`DC_COUNT_WIDTH-1:0]  sum_table  [MAX_WORDS];
    int                          word_total;
    int                          out_index;
    logic                        stim_loaded;
    logic                        saw_full;

    dc_channel_top dc_channel_top_inst
    (
        .clk       (clk),
        .rstn      (rstn),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .in_last   (in_last),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_last  (out_last),
        .out_len   (out_len),
        .out_sum   (out_sum),
        .out_ready (out_ready)
    );

    // Properties see the channel wires and the FIFO internals
    bind dc_channel_top dc_channel_properties properties_inst
    (
        .clk       (clk),
        .rstn      (rstn),
        .wr_valid  (wr_valid),
        .wr_ready  (wr_ready),
        .rd_valid  (rd_valid),
        .rd_ready  (rd_ready),
        .count     (fifo_inst.count),
        .wr_ptr    (fifo_inst.wr_ptr),
        .rd_ptr    (fifo_inst.rd_ptr),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data),
        .out_last  (out_last),
        .out_len   (out_len),
        .out_sum   (out_sum)
    );

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Regression failed");
        $fatal(1, "run stopped at time %0t", $time);
    endtask

    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
            abort_run($sformatf("mismatch at time %0t: %s is %h, expected %h",
                                $time, what, actual, expected));
    endtask

    // Rows are last flag, word, length and checksum; comment lines hold no fields
    task automatic load_stimulus();
        int           fd;
        int           fields;
        string        line;
        logic [31:0]  last_col;
        logic [31:0]  word_col;
        logic [31:0]  len_col;
        logic [31:0]  sum_col;
        fd = $fopen("testbench/dc_channel_stim.txt", "r");
        if (fd == 0)
            abort_run("cannot open the stimulus file testbench/dc_channel_stim.txt");
        word_total = 0;
        while (!$feof(fd))
        begin
            line = "";
            void'($fgets(line, fd));
            fields = $sscanf(line, "%h %h %h %h", last_col, word_col, len_col, sum_col);
            if (fields == 4)
            begin
                if (word_total == MAX_WORDS)
                    abort_run("stimulus file holds more words than the table");
                last_table[word_total] = last_col[0];
                word_table[word_total] = word_col;
                len_table[word_total]  = len_col[`DC_COUNT_WIDTH-1:0];
                sum_table[word_total]  = sum_col[`DC_COUNT_WIDTH-1:0];
                word_total++;
            end
        end
        $fclose(fd);
        if (word_total == 0)
            abort_run("stimulus file holds no words");
    endtask

    // Hold one word on the input until the writer takes it
    task automatic send_word(input int index);
        logic accepted;
        in_valid = 1'b1;
        in_data  = word_table[index];
        in_last  = last_table[index];
        accepted = 1'b0;
        while (!accepted)
        begin
            @(negedge clk);
            accepted = in_ready;
            @(posedge clk);
            #1;
        end
    endtask

    // One output transfer against the next expected row
    task automatic check_output();
        if (out_index >= word_total)
            abort_run("the DUT sent more words than the stimulus holds");
        check_value("out_data", out_data, word_table[out_index]);
        check_value("out_last", 32'(out_last), 32'(last_table[out_index]));
        if (last_table[out_index])
        begin
            check_value("out_len", 32'(out_len), 32'(len_table[out_index]));
            check_value("out_sum", 32'(out_sum), 32'(sum_table[out_index]));
        end
        out_index++;
    endtask

    // ********************
    // Clock and stimulus
    // ********************

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial
    begin
        rstn        = 1'b0;
        in_valid    = 1'b0;
        in_data     = '0;
        in_last     = 1'b0;
        out_ready   = 1'b0;
        out_index   = 0;
        saw_full    = 1'b0;
        stim_loaded = 1'b0;
        void'($urandom(83213));
        load_stimulus();
        stim_loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rstn = 1'b1;
        #1;
        // Both handshakes closed right after reset
        check_value("in_ready after reset", 32'(in_ready), 32'd0);
        check_value("out_valid after reset", 32'(out_valid), 32'd0);
        @(posedge clk);
        #1;
        // Frames go in back to back
        for (int i = 0; i < word_total; i++)
            send_word(i);
        in_valid = 1'b0;
        in_last  = 1'b0;
        wait (out_index == word_total);
        // Quiet tail catches any extra word
        repeat (20) @(posedge clk);
        if (saw_full)
        begin
            $display("Regression passed");
            $finish;
        end
        else
            abort_run("the FIFO never filled under back-pressure");
    end

    // Random out_ready with long stalls
    initial
    begin
        int stall_left;
        stall_left = FIRST_STALL;
        wait (rstn);
        forever
        begin
            @(posedge clk);
            #1;
            if (stall_left > 0)
            begin
                out_ready = 1'b0;
                stall_left--;
            end
            else if ($urandom_range(31) == 0)
            begin
                out_ready  = 1'b0;
                stall_left = $urandom_range(30, 12);
            end
            else
                out_ready = ($urandom_range(3) != 0);
        end
    end

    // ********************
    // Monitor and watchdog
    // ********************

    // Mid-cycle sampling, a transfer lands on the next rising edge
    initial
    begin
        forever
        begin
            @(negedge clk);
            if (rstn && !in_ready && !dc_channel_top_inst.fifo_inst.wr_ready)
                saw_full = 1'b1;
            if (dc_channel_top_inst.properties_inst.failure_count != 0)
                abort_run("a bound assertion on the FIFO or the output handshake failed");
            if (rstn && out_valid && out_ready)
                check_output();
        end
    end

    initial
    begin
        wait (stim_loaded);
        repeat (word_total * CYCLES_PER_WORD) @(posedge clk);
        abort_run($sformatf("timeout, %0d of %0d words seen after %0d cycles",
                            out_index, word_total, word_total * CYCLES_PER_WORD));
    end

endmodule

// ==== testbench/dc_channel_properties.sv ====
`include "dc_defs.svh"

module dc_channel_properties
(
    input  logic                                     clk,
    input  logic                                     rstn,
    input  logic                                     wr_valid,
    input  logic                                     wr_ready,
    input  logic                                     rd_valid,
    input  logic                                     rd_ready,
    input  logic [$clog2(`DC_BUFFER_DEPTH + 1)-1:0]  count,
    input  logic [`DC_BUFFER_DEPTH-1:0]              wr_ptr,
    input  logic [`DC_BUFFER_DEPTH-1:0]              rd_ptr,
    input  logic                                     out_valid,
    input  logic                                     out_ready,
    input  logic [`DC_DATA_WIDTH-1:0]                out_data,
    input  logic                                     out_last,
    input  logic [`DC_COUNT_WIDTH-1:0]               out_len,
    input  logic [`DC_COUNT_WIDTH-1:0]               out_sum
);

    localparam int FULL_COUNT = `DC_BUFFER_DEPTH;

    // Number of assertion failures so far
    int failure_count;

    initial
        failure_count = 0;

    // ********************
    // FIFO
    // ********************

    // Coinciding pointers with entries stored means full
    // No write may land then
    write_when_full: assert property (@(posedge clk) disable iff (!rstn)
        ((count != 0) && (wr_ptr == rd_ptr)) |-> !(wr_valid && wr_ready))
    else
    begin
        failure_count++;
        $error("write into a full FIFO");
    end

    // Coinciding pointers short of full means empty
    // No read may happen then
    read_when_empty: assert property (@(posedge clk) disable iff (!rstn)
        ((count != FULL_COUNT) && (wr_ptr == rd_ptr)) |-> !(rd_valid && rd_ready))
    else
    begin
        failure_count++;
        $error("read from an empty FIFO");
    end

    // Both pointers keep exactly one bit set
    pointers_onehot: assert property (@(posedge clk) disable iff (!rstn)
        $onehot(wr_ptr) && $onehot(rd_ptr))
    else
    begin
        failure_count++;
        $error("FIFO pointer is not one-hot");
    end

    // ********************
    // Output handshake
    // ********************

    // Offered word and frame results frozen until taken
    output_stable: assert property (@(posedge clk) disable iff (!rstn)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data)
        && $stable(out_last) && $stable(out_len) && $stable(out_sum)))
    else
    begin
        failure_count++;
        $error("output changed while out_ready was low");
    end

endmodule

// ==== source/dc_channel_top.sv ====
`include "dc_defs.svh"

module dc_channel_top
(
    input  logic                        clk,
    input  logic                        rstn,
    // Producer side
    input  logic                        in_valid,
    input  logic [`DC_DATA_WIDTH-1:0]   in_data,
    input  logic                        in_last,
    output logic                        in_ready,
    // Consumer side
    output logic                        out_valid,
    output logic [`DC_DATA_WIDTH-1:0]   out_data,
    output logic                        out_last,
    output logic [`DC_COUNT_WIDTH-1:0]  out_len,
    output logic [`DC_COUNT_WIDTH-1:0]  out_sum,
    input  logic                        out_ready
);

    import dc_entry_pkg::*;

    // Writer to FIFO
    logic    wr_valid;
    logic    wr_ready;
    entry_t  wr_entry;

    // FIFO to reader
    logic    rd_valid;
    logic    rd_ready;
    entry_t  rd_entry;

    dc_frame_writer frame_writer_inst
    (
        .clk      (clk),
        .rstn     (rstn),
        .in_valid (in_valid),
        .in_data  (in_data),
        .in_last  (in_last),
        .in_ready (in_ready),
        .wr_valid (wr_valid),
        .wr_entry (wr_entry),
        .wr_ready (wr_ready)
    );

    dc_fifo fifo_inst
    (
        .clk      (clk),
        .rstn     (rstn),
        .wr_valid (wr_valid),
        .wr_entry (wr_entry),
        .wr_ready (wr_ready),
        .rd_valid (rd_valid),
        .rd_entry (rd_entry),
        .rd_ready (rd_ready)
    );

    dc_frame_reader frame_reader_inst
    (
        .clk       (clk),
        .rstn      (rstn),
        .rd_valid  (rd_valid),
        .rd_entry  (rd_entry),
        .rd_ready  (rd_ready),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_last  (out_last),
        .out_len   (out_len),
        .out_sum   (out_sum),
        .out_ready (out_ready)
    );

endmodule

// ==== source/dc_frame_reader.sv ====
`include "dc_defs.svh"

module dc_frame_reader
(
    input  logic                        clk,
    input  logic                        rstn,
    input  logic                        rd_valid,
    input  dc_entry_pkg::entry_t        rd_entry,
    output logic                        rd_ready,
    output logic                        out_valid,
    output logic [`DC_DATA_WIDTH-1:0]   out_data,
    output logic                        out_last,
    output logic [`DC_COUNT_WIDTH-1:0]  out_len,
    output logic [`DC_COUNT_WIDTH-1:0]  out_sum,
    input  logic                        out_ready
);

    import dc_entry_pkg::*;

    logic                       held;
    logic [`DC_DATA_WIDTH-1:0]  held_data;
    logic                       rd_fire;
    logic                       rd_is_trailer;

    // ********************
    // Handshake
    // ********************

    // Any read may load the output register, so reads follow out_ready
    assign rd_ready = out_ready;
    assign rd_fire  = rd_valid && rd_ready;

    assign rd_is_trailer = (rd_entry.kind == KIND_TRAILER);

    // ********************
    // Hold and release
    // ********************

    // A held word leaves on any following entry
    // Held flag survives only when the new entry is data
    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            held      <= 1'b0;
            out_valid <= 1'b0;
        end
        else if (out_ready)
        begin
            out_valid <= rd_valid && held;
            if (rd_valid)
                held <= !rd_is_trailer;
        end
    end

    // Output payload, frozen while out_ready is low
    always_ff @(posedge clk)
    begin
        if (rd_fire && held)
        begin
            out_data <= held_data;
            out_last <= rd_is_trailer;
        end
        // Frame results come from the trailer view
        if (rd_fire && rd_is_trailer)
        begin
            out_len <= rd_entry.word.trailer[TRAILER_LEN];
            out_sum <= rd_entry.word.trailer[TRAILER_SUM];
        end
        if (rd_fire && !rd_is_trailer)
            held_data <= rd_entry.word.data;
    end

endmodule

// ==== source/dc_frame_writer.sv ====
`include "dc_defs.svh"

module dc_frame_writer
(
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       in_valid,
    input  logic [`DC_DATA_WIDTH-1:0]  in_data,
    input  logic                       in_last,
    output logic                       in_ready,
    output logic                       wr_valid,
    output dc_entry_pkg::entry_t       wr_entry,
    input  logic                       wr_ready
);

    import dc_entry_pkg::*;
    import dc_frame_pkg::*;

    logic                        started;
    logic                        trailer_pending;
    logic                        trailer_busy;
    logic [`DC_COUNT_WIDTH-1:0]  len_acc;
    logic [`DC_COUNT_WIDTH-1:0]  sum_acc;
    logic                        in_fire;
    logic                        wr_fire;
    logic                        load_trailer;
    logic                        trailer_done;

    // ********************
    // Handshake
    // ********************

    assign wr_fire = wr_valid && wr_ready;
    assign in_fire = in_valid && in_ready;

    // Trailer still owed or still sitting in the output register
    assign trailer_busy = trailer_pending || (wr_valid && (wr_entry.kind == KIND_TRAILER));

    // Input opens one cycle after reset release
    // Closed while a trailer is in flight or the output slot is stuck
    assign in_ready = started && !trailer_busy && (!wr_valid || wr_ready);

    // Trailer goes out once the final data entry has left
    assign load_trailer = trailer_pending && (!wr_valid || wr_fire);
    assign trailer_done = wr_fire && (wr_entry.kind == KIND_TRAILER);

    // ********************
    // Control and accumulators
    // ********************

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            started         <= 1'b0;
            wr_valid        <= 1'b0;
            trailer_pending <= 1'b0;
            len_acc         <= '0;
            sum_acc         <= '0;
        end
        else
        begin
            started <= 1'b1;
            if (in_fire)
            begin
                wr_valid        <= 1'b1;
                trailer_pending <= in_last;
                len_acc         <= len_acc + 1'b1;
                sum_acc         <= fold_checksum(sum_acc, in_data);
            end
            else if (load_trailer)
            begin
                wr_valid        <= 1'b1;
                trailer_pending <= 1'b0;
            end
            else if (wr_fire)
            begin
                wr_valid <= 1'b0;
            end
            // Fresh frame starts after the trailer is taken
            if (trailer_done)
            begin
                len_acc <= '0;
                sum_acc <= '0;
            end
        end
    end

    // Output entry payload
    always_ff @(posedge clk)
    begin
        if (in_fire)
        begin
            wr_entry.kind      <= KIND_DATA;
            wr_entry.word.data <= in_data;
        end
        else if (load_trailer)
        begin
            wr_entry.kind                      <= KIND_TRAILER;
            wr_entry.word.trailer[TRAILER_LEN] <= len_acc;
            wr_entry.word.trailer[TRAILER_SUM] <= sum_acc;
        end
    end

endmodule

// ==== source/dc_fifo.sv ====
`include "dc_defs.svh"

module dc_fifo
(
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  wr_valid,
    input  dc_entry_pkg::entry_t  wr_entry,
    output logic                  wr_ready,
    output logic                  rd_valid,
    output dc_entry_pkg::entry_t  rd_entry,
    input  logic                  rd_ready
);

    // Occupancy needs one more code than the depth
    localparam int COUNT_BITS = $clog2(`DC_BUFFER_DEPTH + 1);
    localparam logic [COUNT_BITS-1:0] FULL_COUNT = COUNT_BITS'(`DC_BUFFER_DEPTH);

    logic [`DC_BUFFER_DEPTH-1:0] wr_ptr;
    logic [`DC_BUFFER_DEPTH-1:0] rd_ptr;
    logic [COUNT_BITS-1:0]       count;
    logic                        wr_fire;
    logic                        rd_fire;

    // ********************
    // Handshake
    // ********************

    assign wr_ready = (count != FULL_COUNT);
    assign rd_valid = (count != '0);

    assign wr_fire = wr_valid && wr_ready;
    assign rd_fire = rd_valid && rd_ready;

    // ********************
    // Pointers and occupancy
    // ********************

    // Both pointers start at entry 0 and rotate left per transfer
    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            wr_ptr <= `DC_BUFFER_DEPTH'(1);
            rd_ptr <= `DC_BUFFER_DEPTH'(1);
        end
        else
        begin
            if (wr_fire)
                wr_ptr <= {wr_ptr[`DC_BUFFER_DEPTH-2:0], wr_ptr[`DC_BUFFER_DEPTH-1]};
            if (rd_fire)
                rd_ptr <= {rd_ptr[`DC_BUFFER_DEPTH-2:0], rd_ptr[`DC_BUFFER_DEPTH-1]};
        end
    end

    // Read and write in one cycle cancel out
    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
            count <= '0;
        else
        begin
            case ({wr_fire, rd_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage
    dc_data_buffer data_buffer_inst
    (
        .clk           (clk),
        .rstn          (rstn),
        .write_enable  (wr_fire),
        .write_pointer (wr_ptr),
        .write_data    (wr_entry),
        .read_pointer  (rd_ptr),
        .read_data     (rd_entry)
    );

endmodule

// ==== source/dc_data_buffer.sv ====
`include "dc_defs.svh"

module dc_data_buffer
(
    input  logic                         clk,
    input  logic                         rstn,
    input  logic                         write_enable,
    input  logic [`DC_BUFFER_DEPTH-1:0]  write_pointer,
    input  dc_entry_pkg::entry_t         write_data,
    input  logic [`DC_BUFFER_DEPTH-1:0]  read_pointer,
    output dc_entry_pkg::entry_t         read_data
);

    import dc_entry_pkg::*;

    localparam int INDEX_WIDTH = $clog2(`DC_BUFFER_DEPTH);

    // One-hot to binary index, OR of the set positions
    function automatic logic [INDEX_WIDTH-1:0] onehot_to_index
    (
        input logic [`DC_BUFFER_DEPTH-1:0] onehot
    );
        logic [INDEX_WIDTH-1:0] index;
        index = '0;
        for (int i = 0; i < `DC_BUFFER_DEPTH; i++)
        begin
            if (onehot[i])
                index = index | INDEX_WIDTH'(i);
        end
        return index;
    endfunction

    // Storage array
    entry_t entries [`DC_BUFFER_DEPTH];

    logic [INDEX_WIDTH-1:0] write_index;
    logic [INDEX_WIDTH-1:0] read_index;

    assign write_index = onehot_to_index(write_pointer);
    assign read_index  = onehot_to_index(read_pointer);

    // Every entry comes out of reset as zero
    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            for (int i = 0; i < `DC_BUFFER_DEPTH; i++)
                entries[i] <= '0;
        end
        else if (write_enable)
        begin
            entries[write_index] <= write_data;
        end
    end

    // Read side is combinational
    assign read_data = entries[read_index];

endmodule

// ==== source/dc_frame_pkg.sv ====
`include "dc_defs.svh"

package dc_frame_pkg;

    // Half-word split of a payload word
    localparam int HALF_WIDTH = `DC_DATA_WIDTH / 2;

    // Fold one payload word into the running frame checksum
    // Upper and lower halves are both XORed in
    function automatic logic [`DC_COUNT_WIDTH-1:0] fold_checksum
    (
        input logic [`DC_COUNT_WIDTH-1:0] running,
        input logic [`DC_DATA_WIDTH-1:0]  word
    );
        logic [`DC_COUNT_WIDTH-1:0] upper_half;
        logic [`DC_COUNT_WIDTH-1:0] lower_half;
        upper_half = word[`DC_DATA_WIDTH-1:HALF_WIDTH];
        lower_half = word[HALF_WIDTH-1:0];
        return running ^ upper_half ^ lower_half;
    endfunction

endpackage

// ==== source/dc_entry_pkg.sv ====
`include "dc_defs.svh"

package dc_entry_pkg;

    // Entry kind bit
    localparam logic KIND_DATA    = 1'b0;
    localparam logic KIND_TRAILER = 1'b1;

    // Halves of the trailer view
    // Word count sits in the upper half, checksum in the lower half
    localparam int TRAILER_LEN = 1;
    localparam int TRAILER_SUM = 0;

    // One entry word, read either as payload or as trailer
    typedef union packed
    {
        logic [`DC_DATA_WIDTH-1:0]        data;
        logic [1:0][`DC_COUNT_WIDTH-1:0]  trailer;
    } entry_word_t;

    // FIFO entry
    // Kind bit on top, word below it
    typedef struct packed
    {
        logic         kind;
        entry_word_t  word;
    } entry_t;

endpackage

// ==== source/dc_defs.svh ====
`ifndef DC_DEFS_SVH
`define DC_DEFS_SVH

// ********************
// Channel dimensions
// ********************

// Payload word width
`define DC_DATA_WIDTH 32

// FIFO entries, also the width of each one-hot pointer
`define DC_BUFFER_DEPTH 8

// Frame word count and checksum width
// Count wraps modulo 2**DC_COUNT_WIDTH
`define DC_COUNT_WIDTH 16

`endif
